// ==== Bender.yml ====
package:
  name: mips_pipeline

sources:
  - rtl/mips_pkg.sv
  - rtl/fetch_stage.sv
  - rtl/decode_stage.sv
  - rtl/execute_stage.sv
  - rtl/memory_stage.sv
  - rtl/hazard_unit.sv
  - rtl/mips_pipeline.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_mips_pipeline.sv

// ==== list.f ====
+incdir+tests
rtl/mips_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/hazard_unit.sv
rtl/mips_pipeline.sv
tests/tb_mips_pipeline.sv

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
   input  wire                     i_clock,
   input  wire                     reset,
   input  wire mips_pkg::if_id_t   i_if_id,
   input  wire mips_pkg::commit_t  i_commit,
   input  wire                     i_stall,
   input  wire                     i_fwd_branch_a,
   input  wire                     i_fwd_branch_b,
   input  wire mips_pkg::word_t    i_ex_mem_result,
   output mips_pkg::id_ex_t        o_id_ex,
   output logic                    o_redirect,
   output mips_pkg::word_t         o_target,
   output logic                    o_uses_rs,
   output logic                    o_uses_rt
);

   mips_pkg::opcode_e   opcode;
   mips_pkg::funct_e    funct;
   mips_pkg::reg_addr_t rs;
   mips_pkg::reg_addr_t rt;
   mips_pkg::reg_addr_t dest;
   mips_pkg::word_t     imm_ext;
   mips_pkg::word_t     pc_plus4;
   mips_pkg::word_t     rs_val;
   mips_pkg::word_t     rt_val;
   mips_pkg::alu_op_e   alu_op;
   logic                use_imm;
   logic                mem_read;
   logic                mem_write;
   logic                reg_write;
   logic                halt;
   logic                is_beq;
   logic                is_j;
   logic                known;
   logic                taken;
   mips_pkg::word_t     regs [32];

   assign opcode   = mips_pkg::opcode_e'(i_if_id.instr[31:26]);
   assign funct    = mips_pkg::funct_e'(i_if_id.instr[5:0]);
   assign rs       = i_if_id.instr[25:21];
   assign rt       = i_if_id.instr[20:16];
   assign imm_ext  = {{16{i_if_id.instr[15]}}, i_if_id.instr[15:0]};
   assign pc_plus4 = i_if_id.pc + 'd4;

   always_comb begin
      alu_op    = mips_pkg::ALU_ADD;
      use_imm   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      reg_write = 1'b0;
      halt      = 1'b0;
      is_beq    = 1'b0;
      is_j      = 1'b0;
      known     = 1'b1;
      o_uses_rs = 1'b0;
      o_uses_rt = 1'b0;
      dest      = rt;
      case (opcode)
         mips_pkg::OP_RTYPE: begin
            o_uses_rs = 1'b1;
            o_uses_rt = 1'b1;
            reg_write = 1'b1;
            dest      = i_if_id.instr[15:11];
            case (funct)
               mips_pkg::FN_ADDU: alu_op = mips_pkg::ALU_ADD;
               mips_pkg::FN_SUBU: alu_op = mips_pkg::ALU_SUB;
               mips_pkg::FN_AND:  alu_op = mips_pkg::ALU_AND;
               mips_pkg::FN_OR:   alu_op = mips_pkg::ALU_OR;
               mips_pkg::FN_SLT:  alu_op = mips_pkg::ALU_SLT;
               default:           known  = 1'b0;
            endcase
         end
         mips_pkg::OP_ADDI: begin
            o_uses_rs = 1'b1;
            use_imm   = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::OP_LW: begin
            o_uses_rs = 1'b1;
            use_imm   = 1'b1;
            mem_read  = 1'b1;
            reg_write = 1'b1;
         end
         mips_pkg::OP_SW: begin
            o_uses_rs = 1'b1;
            o_uses_rt = 1'b1;
            use_imm   = 1'b1;
            mem_write = 1'b1;
         end
         mips_pkg::OP_BEQ: begin
            o_uses_rs = 1'b1;
            o_uses_rt = 1'b1;
            is_beq    = 1'b1;
         end
         mips_pkg::OP_J:    is_j  = 1'b1;
         mips_pkg::OP_HALT: halt  = 1'b1;
         default:           known = 1'b0;
      endcase
   end

   // Write-before-read bypass from the commit port
   always_comb begin
      rs_val = (rs == '0) ? '0 : regs[rs];
      rt_val = (rt == '0) ? '0 : regs[rt];
      if (i_commit.valid && i_commit.rd == rs) rs_val = i_commit.data;
      if (i_commit.valid && i_commit.rd == rt) rt_val = i_commit.data;
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (i_commit.valid) begin
         regs[i_commit.rd] <= i_commit.data;
      end
   end

   assign taken      = is_beq && ((i_fwd_branch_a ? i_ex_mem_result : rs_val) ==
                                  (i_fwd_branch_b ? i_ex_mem_result : rt_val));
   assign o_redirect = i_if_id.valid && known && !i_stall && (is_j || taken);
   assign o_target   = is_j ? {pc_plus4[31:28], i_if_id.instr[25:0], 2'b00}
                            : pc_plus4 + {imm_ext[29:0], 2'b00};

   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_id_ex.valid <= 1'b0;
      end else begin
         o_id_ex.valid     <= i_if_id.valid && known && !i_stall;
         o_id_ex.alu_op    <= alu_op;
         o_id_ex.use_imm   <= use_imm;
         o_id_ex.mem_read  <= mem_read;
         o_id_ex.mem_write <= mem_write;
         o_id_ex.reg_write <= reg_write;
         o_id_ex.halt      <= halt;
         o_id_ex.rs        <= rs;
         o_id_ex.rt        <= rt;
         o_id_ex.rd        <= dest;
         o_id_ex.rs_val    <= rs_val;
         o_id_ex.rt_val    <= rt_val;
         o_id_ex.imm       <= imm_ext;
      end
   end

   assert property (@(posedge i_clock) disable iff (reset)
      i_if_id.valid && !(opcode inside {mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI,
         mips_pkg::OP_LW, mips_pkg::OP_SW, mips_pkg::OP_BEQ, mips_pkg::OP_J,
         mips_pkg::OP_HALT}) |=> !o_id_ex.valid);

   // Target reaches decode right after the one squashed slot
   assert property (@(posedge i_clock) disable iff (reset)
      o_redirect |=> ##1 (!i_if_id.valid || i_if_id.pc == $past(o_target, 2)));

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
   input  wire                      i_clock,
   input  wire                      reset,
   input  wire mips_pkg::id_ex_t    i_id_ex,
   input  wire mips_pkg::fwd_sel_e  i_fwd_a,
   input  wire mips_pkg::fwd_sel_e  i_fwd_b,
   input  wire mips_pkg::word_t     i_mem_wb_result,
   output mips_pkg::ex_mem_t        o_ex_mem
);

   mips_pkg::word_t op_a;
   mips_pkg::word_t fwd_b_val;
   mips_pkg::word_t op_b;
   mips_pkg::word_t result;

   function automatic mips_pkg::word_t pick(input mips_pkg::fwd_sel_e sel,
                                            input mips_pkg::word_t    reg_val);
      case (sel)
         mips_pkg::FWD_EX_MEM: return o_ex_mem.alu_result;
         mips_pkg::FWD_MEM_WB: return i_mem_wb_result;
         default:              return reg_val;
      endcase
   endfunction

   always_comb begin
      op_a      = pick(i_fwd_a, i_id_ex.rs_val);
      fwd_b_val = pick(i_fwd_b, i_id_ex.rt_val);
      op_b      = i_id_ex.use_imm ? i_id_ex.imm : fwd_b_val;
      case (i_id_ex.alu_op)
         mips_pkg::ALU_SUB: result = op_a - op_b;
         mips_pkg::ALU_AND: result = op_a & op_b;
         mips_pkg::ALU_OR:  result = op_a | op_b;
         mips_pkg::ALU_SLT: result = {31'd0, $signed(op_a) < $signed(op_b)};
         default:           result = op_a + op_b;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_ex_mem.valid <= 1'b0;
      end else begin
         o_ex_mem.valid      <= i_id_ex.valid;
         o_ex_mem.mem_read   <= i_id_ex.mem_read;
         o_ex_mem.mem_write  <= i_id_ex.mem_write;
         o_ex_mem.reg_write  <= i_id_ex.reg_write;
         o_ex_mem.halt       <= i_id_ex.halt;
         o_ex_mem.rd         <= i_id_ex.rd;
         o_ex_mem.alu_result <= result;
         o_ex_mem.store_data <= fwd_b_val;
      end
   end

   // Bubbles in execute never pull forwarded data
   assert property (@(posedge i_clock) disable iff (reset)
      !i_id_ex.valid |-> (i_fwd_a == mips_pkg::FWD_NONE && i_fwd_b == mips_pkg::FWD_NONE));

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
   parameter int IMEM_DEPTH = 1024
) (
   input  wire                         i_clock,
   input  wire                         reset,
   input  wire                         i_run,
   input  wire mips_pkg::imem_write_t  i_imem_write,
   input  wire                         i_stall,
   input  wire                         i_redirect,
   input  wire mips_pkg::word_t        i_target,
   input  wire                         i_halted,
   output mips_pkg::if_id_t            o_if_id
);

   localparam int AW = $clog2(IMEM_DEPTH);

   mips_pkg::word_t              pc_q;
   logic [mips_pkg::INSTR_W-1:0] imem [IMEM_DEPTH];

   // Program load, core idle
   always_ff @(posedge i_clock) begin
      if (i_imem_write.we && !i_run) begin
         imem[i_imem_write.addr[AW-1:0]] <= i_imem_write.data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset || !i_run) begin
         pc_q <= '0;
      end else if (!i_halted) begin
         if (i_redirect) begin
            pc_q <= i_target;
         end else if (!i_stall) begin
            pc_q <= pc_q + 'd4;
         end
      end
   end

   // Redirect squashes the one younger instruction
   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_if_id.valid <= 1'b0;
      end else if (!i_run || i_halted || i_redirect) begin
         o_if_id.valid <= 1'b0;
      end else if (!i_stall) begin
         o_if_id.valid <= 1'b1;
         o_if_id.pc    <= pc_q;
         o_if_id.instr <= imem[pc_q[AW+1:2]];
      end
   end

   // Loads only happen while the core is held idle
   assert property (@(posedge i_clock) disable iff (reset)
      i_run |-> !i_imem_write.we);

endmodule

`default_nettype wire

// ==== rtl/hazard_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
   input  wire mips_pkg::if_id_t   i_if_id,
   input  wire                     i_uses_rs,
   input  wire                     i_uses_rt,
   input  wire mips_pkg::id_ex_t   i_id_ex,
   input  wire mips_pkg::ex_mem_t  i_ex_mem,
   input  wire mips_pkg::mem_wb_t  i_mem_wb,
   output logic                    o_stall,
   output mips_pkg::fwd_sel_e      o_fwd_a,
   output mips_pkg::fwd_sel_e      o_fwd_b,
   output logic                    o_fwd_branch_a,
   output logic                    o_fwd_branch_b
);

   mips_pkg::reg_addr_t rs;
   mips_pkg::reg_addr_t rt;
   logic                is_beq;
   logic                load_use;
   logic                beq_on_ex;
   logic                beq_on_load;
   logic                ex_wr;
   logic                mem_wr;

   // EX/MEM wins over MEM/WB
   function automatic mips_pkg::fwd_sel_e fwd_select(input mips_pkg::reg_addr_t src);
      if (!i_id_ex.valid || src == '0) return mips_pkg::FWD_NONE;
      if (i_ex_mem.valid && i_ex_mem.reg_write && i_ex_mem.rd == src)
         return mips_pkg::FWD_EX_MEM;
      if (i_mem_wb.valid && i_mem_wb.reg_write && i_mem_wb.rd == src)
         return mips_pkg::FWD_MEM_WB;
      return mips_pkg::FWD_NONE;
   endfunction

   always_comb begin
      rs     = i_if_id.instr[25:21];
      rt     = i_if_id.instr[20:16];
      is_beq = i_if_id.valid && (i_if_id.instr[31:26] == mips_pkg::OP_BEQ);
      ex_wr  = i_id_ex.valid && i_id_ex.reg_write && (i_id_ex.rd != '0);
      mem_wr = i_ex_mem.valid && i_ex_mem.reg_write && (i_ex_mem.rd != '0);

      load_use    = i_if_id.valid && ex_wr && i_id_ex.mem_read &&
                    ((i_uses_rs && rs == i_id_ex.rd) || (i_uses_rt && rt == i_id_ex.rd));
      beq_on_ex   = is_beq && ex_wr && (rs == i_id_ex.rd || rt == i_id_ex.rd);
      beq_on_load = is_beq && mem_wr && i_ex_mem.mem_read &&
                    (rs == i_ex_mem.rd || rt == i_ex_mem.rd);
      o_stall     = load_use || beq_on_ex || beq_on_load;

      o_fwd_branch_a = mem_wr && !i_ex_mem.mem_read && (rs == i_ex_mem.rd);
      o_fwd_branch_b = mem_wr && !i_ex_mem.mem_read && (rt == i_ex_mem.rd);
      o_fwd_a        = fwd_select(i_id_ex.rs);
      o_fwd_b        = fwd_select(i_id_ex.rt);
   end

endmodule

`default_nettype wire

// ==== rtl/memory_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_stage #(
   parameter int DMEM_DEPTH = 1024
) (
   input  wire                      i_clock,
   input  wire                      reset,
   input  wire mips_pkg::ex_mem_t   i_ex_mem,
   output mips_pkg::mem_wb_t        o_mem_wb,
   output mips_pkg::commit_t        o_commit,
   output logic                     o_halted
);

   localparam int AW = $clog2(DMEM_DEPTH);

   mips_pkg::word_t dmem [DMEM_DEPTH];
   logic [AW-1:0]   addr;
   logic            halted_q;

   assign addr = i_ex_mem.alu_result[AW+1:2];

   // Stores behind a HALT are dropped
   always_ff @(posedge i_clock) begin
      if (i_ex_mem.valid && i_ex_mem.mem_write && !o_halted) begin
         dmem[addr] <= i_ex_mem.store_data;
      end
   end

   always_ff @(posedge i_clock) begin
      if (reset) begin
         o_mem_wb.valid <= 1'b0;
         halted_q       <= 1'b0;
      end else begin
         o_mem_wb.valid     <= i_ex_mem.valid;
         o_mem_wb.reg_write <= i_ex_mem.reg_write;
         o_mem_wb.halt      <= i_ex_mem.halt;
         o_mem_wb.rd        <= i_ex_mem.rd;
         o_mem_wb.result    <= i_ex_mem.mem_read ? dmem[addr] : i_ex_mem.alu_result;
         if (o_mem_wb.valid && o_mem_wb.halt) halted_q <= 1'b1;
      end
   end

   assign o_halted = halted_q || (o_mem_wb.valid && o_mem_wb.halt);

   assign o_commit.valid = o_mem_wb.valid && o_mem_wb.reg_write &&
                           (o_mem_wb.rd != '0) && !o_halted;
   assign o_commit.rd    = o_mem_wb.rd;
   assign o_commit.data  = o_mem_wb.result;

endmodule

`default_nettype wire

// ==== rtl/mips_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pipeline #(
   parameter int IMEM_DEPTH = 1024,
   parameter int DMEM_DEPTH = 1024
) (
   input  wire                         i_clock,
   input  wire                         reset,
   input  wire                         i_run,
   input  wire mips_pkg::imem_write_t  i_imem_write,
   output mips_pkg::commit_t           o_commit,
   output logic                        o_halted
);

   mips_pkg::if_id_t   if_id;
   mips_pkg::id_ex_t   id_ex;
   mips_pkg::ex_mem_t  ex_mem;
   mips_pkg::mem_wb_t  mem_wb;

   logic               redirect;
   mips_pkg::word_t    target;
   logic               uses_rs;
   logic               uses_rt;

   logic               stall;
   mips_pkg::fwd_sel_e fwd_a;
   mips_pkg::fwd_sel_e fwd_b;
   logic               fwd_branch_a;
   logic               fwd_branch_b;

   fetch_stage #(
      .IMEM_DEPTH (IMEM_DEPTH)
   ) u_fetch_stage (
      .i_clock      (i_clock),
      .reset        (reset),
      .i_run        (i_run),
      .i_imem_write (i_imem_write),
      .i_stall      (stall),
      .i_redirect   (redirect),
      .i_target     (target),
      .i_halted     (o_halted),
      .o_if_id      (if_id)
   );

   decode_stage u_decode_stage (
      .i_clock         (i_clock),
      .reset           (reset),
      .i_if_id         (if_id),
      .i_commit        (o_commit),
      .i_stall         (stall),
      .i_fwd_branch_a  (fwd_branch_a),
      .i_fwd_branch_b  (fwd_branch_b),
      .i_ex_mem_result (ex_mem.alu_result),
      .o_id_ex         (id_ex),
      .o_redirect      (redirect),
      .o_target        (target),
      .o_uses_rs       (uses_rs),
      .o_uses_rt       (uses_rt)
   );

   execute_stage u_execute_stage (
      .i_clock         (i_clock),
      .reset           (reset),
      .i_id_ex         (id_ex),
      .i_fwd_a         (fwd_a),
      .i_fwd_b         (fwd_b),
      .i_mem_wb_result (mem_wb.result),
      .o_ex_mem        (ex_mem)
   );

   memory_stage #(
      .DMEM_DEPTH (DMEM_DEPTH)
   ) u_memory_stage (
      .i_clock  (i_clock),
      .reset    (reset),
      .i_ex_mem (ex_mem),
      .o_mem_wb (mem_wb),
      .o_commit (o_commit),
      .o_halted (o_halted)
   );

   hazard_unit u_hazard_unit (
      .i_if_id        (if_id),
      .i_uses_rs      (uses_rs),
      .i_uses_rt      (uses_rt),
      .i_id_ex        (id_ex),
      .i_ex_mem       (ex_mem),
      .i_mem_wb       (mem_wb),
      .o_stall        (stall),
      .o_fwd_a        (fwd_a),
      .o_fwd_b        (fwd_b),
      .o_fwd_branch_a (fwd_branch_a),
      .o_fwd_branch_b (fwd_branch_b)
   );

endmodule

`default_nettype wire

// ==== rtl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

   localparam int XLEN        = 32;
   localparam int REG_ADDR_W  = 5;
   localparam int INSTR_W     = 32;
   localparam int IMEM_ADDR_W = 10;

   typedef logic [XLEN-1:0]       word_t;
   typedef logic [REG_ADDR_W-1:0] reg_addr_t;

   // Primary opcode field, instr[31:26]
   typedef enum logic [5:0] {
      OP_RTYPE = 6'b000000,
      OP_J     = 6'b000010,
      OP_BEQ   = 6'b000100,
      OP_ADDI  = 6'b001000,
      OP_LW    = 6'b100011,
      OP_SW    = 6'b101011,
      OP_HALT  = 6'b111111
   } opcode_e;

   // R-type function field, instr[5:0]
   typedef enum logic [5:0] {
      FN_ADDU = 6'b100001,
      FN_SUBU = 6'b100011,
      FN_AND  = 6'b100100,
      FN_OR   = 6'b100101,
      FN_SLT  = 6'b101010
   } funct_e;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_e;

   typedef enum logic [1:0] {
      FWD_NONE   = 2'd0,
      FWD_EX_MEM = 2'd1,
      FWD_MEM_WB = 2'd2
   } fwd_sel_e;

   typedef struct packed {
      logic                     we;
      logic [IMEM_ADDR_W-1:0]   addr;
      logic [INSTR_W-1:0]       data;
   } imem_write_t;

   typedef struct packed {
      logic                     valid;
      word_t                    pc;
      logic [INSTR_W-1:0]       instr;
   } if_id_t;

   typedef struct packed {
      logic      valid;
      alu_op_e   alu_op;
      logic      use_imm;
      logic      mem_read;
      logic      mem_write;
      logic      reg_write;
      logic      halt;
      reg_addr_t rs;
      reg_addr_t rt;
      reg_addr_t rd;
      word_t     rs_val;
      word_t     rt_val;
      word_t     imm;
   } id_ex_t;

   typedef struct packed {
      logic      valid;
      logic      mem_read;
      logic      mem_write;
      logic      reg_write;
      logic      halt;
      reg_addr_t rd;
      word_t     alu_result;
      word_t     store_data;
   } ex_mem_t;

   typedef struct packed {
      logic      valid;
      logic      reg_write;
      logic      halt;
      reg_addr_t rd;
      word_t     result;
   } mem_wb_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t rd;
      word_t     data;
   } commit_t;

endpackage

`default_nettype wire

// ==== tests/tb_isa_model.svh ====
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// Standard MIPS opcode and function codes
localparam logic [5:0] ADDI_OP = 6'h08;
localparam logic [5:0] LW_OP   = 6'h23;
localparam logic [5:0] SW_OP   = 6'h2b;
localparam logic [5:0] BEQ_OP  = 6'h04;
localparam logic [5:0] ADDU_FN = 6'h21;
localparam logic [5:0] SUBU_FN = 6'h23;
localparam logic [5:0] AND_FN  = 6'h24;
localparam logic [5:0] OR_FN   = 6'h25;
localparam logic [5:0] SLT_FN  = 6'h2a;
localparam logic [5:0] ALU_FNS [5] = '{ADDU_FN, SUBU_FN, AND_FN, OR_FN, SLT_FN};
localparam logic [31:0] HALT_WORD = 32'hfc00_0000;

function automatic logic [31:0] rtype(input logic [5:0] fn, input int rd, input int rs,
                                      input int rt);
   return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic logic [31:0] itype(input logic [5:0] op, input int rt, input int rs,
                                      input int imm);
   return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic logic [31:0] jump(input int index);
   return {6'h02, 26'(index)};
endfunction

// Sequential execution of prog, no delay slot, fills exp_q
task automatic run_model();
   mips_pkg::word_t     regs [32];
   mips_pkg::word_t     dmem [int];
   mips_pkg::word_t     pc;
   mips_pkg::word_t     a;
   mips_pkg::word_t     b;
   mips_pkg::word_t     imm;
   mips_pkg::word_t     res;
   mips_pkg::reg_addr_t dst;
   mips_pkg::commit_t   c;
   logic [31:0]         ins;
   logic                wr;
   exp_q.delete();
   foreach (regs[i]) regs[i] = '0;
   pc = '0;
   while ((pc >> 2) < prog.size()) begin
      ins = prog[pc >> 2];
      a   = regs[ins[25:21]];
      b   = regs[ins[20:16]];
      imm = {{16{ins[15]}}, ins[15:0]};
      pc  = pc + 4;
      dst = ins[20:16];
      wr  = 1'b0;
      res = '0;
      if (ins[31:26] == HALT_WORD[31:26]) break;
      case (ins[31:26])
         6'h00: begin
            dst = ins[15:11];
            wr  = 1'b1;
            case (ins[5:0])
               ADDU_FN: res = a + b;
               SUBU_FN: res = a - b;
               AND_FN:  res = a & b;
               OR_FN:   res = a | b;
               default: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            endcase
         end
         ADDI_OP: begin
            res = a + imm;
            wr  = 1'b1;
         end
         LW_OP: begin
            res = dmem[int'((a + imm) >> 2)];
            wr  = 1'b1;
         end
         SW_OP:   dmem[int'((a + imm) >> 2)] = b;
         BEQ_OP:  if (a == b) pc = pc + (imm << 2);
         default: pc = {pc[31:28], ins[25:0], 2'b00};
      endcase
      if (wr && dst != '0) begin
         regs[dst] = res;
         c.valid   = 1'b1;
         c.rd      = dst;
         c.data    = res;
         exp_q.push_back(c);
      end
   end
endtask

`endif

// ==== tests/tb_mips_pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_pipeline;

   localparam int PAD_HALTS = 4;

   logic                  i_clock;
   logic                  reset;
   logic                  i_run;
   mips_pkg::imem_write_t i_imem_write;
   mips_pkg::commit_t     o_commit;
   logic                  o_halted;

   logic [31:0]           prog [$];
   mips_pkg::commit_t     exp_q [$];
   int                    error_count = 0;
   int                    test_count = 0;
   int                    fail_tests = 0;
   int                    budget_cycles = 0;
   int                    cycle_count = 0;

   `include "tb_isa_model.svh"

   mips_pipeline #(
      .IMEM_DEPTH (1024),
      .DMEM_DEPTH (1024)
   ) u_mips_pipeline (
      .i_clock      (i_clock),
      .reset        (reset),
      .i_run        (i_run),
      .i_imem_write (i_imem_write),
      .o_commit     (o_commit),
      .o_halted     (o_halted)
   );

   always #4 i_clock = ~i_clock;

   // Budget grows as each program is started
   initial begin : watchdog
      while (cycle_count <= budget_cycles) begin
         @(posedge i_clock);
         cycle_count++;
      end
      $display("Watchdog expired after %0d cycles, the DUT never halted", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
   end

   task automatic check_commit(input mips_pkg::commit_t got, input mips_pkg::commit_t exp,
                               input string name);
      if (got.valid !== exp.valid || (exp.valid && (got.rd !== exp.rd ||
          got.data !== exp.data))) begin
         $display("Error at %0t: %s got valid=%b rd=%0d data=%h, expected valid=%b rd=%0d data=%h",
                  $time, name, got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
         error_count++;
      end
   endtask

   task automatic check_halt(input logic got, input logic exp, input string name);
      if (got !== exp) begin
         $display("Error at %0t: %s got %b, expected %b", $time, name, got, exp);
         error_count++;
      end
   endtask

   task automatic reset_dut();
      @(posedge i_clock);
      reset        <= 1'b1;
      i_run        <= 1'b0;
      i_imem_write <= '0;
      repeat (3) @(posedge i_clock);
      reset <= 1'b0;
   endtask

   // Trailing HALT words keep stale memory out of the fetch path
   task automatic load_program();
      for (int i = 0; i < prog.size() + PAD_HALTS; i++) begin
         @(posedge i_clock);
         i_imem_write.we   <= 1'b1;
         i_imem_write.addr <= 10'(i);
         i_imem_write.data <= (i < prog.size()) ? prog[i] : HALT_WORD;
      end
      @(posedge i_clock);
      i_imem_write <= '0;
      i_run        <= 1'b1;
   endtask

   task automatic run_program(input string name);
      mips_pkg::commit_t idle_commit;
      idle_commit   = '0;
      budget_cycles += prog.size() * 3 + 20;
      run_model();
      reset_dut();
      load_program();
      @(negedge i_clock);
      while (!o_halted) begin
         if (o_commit.valid && exp_q.size() == 0) begin
            $display("Error at %0t: %s made an extra commit to r%0d", $time, name, o_commit.rd);
            error_count++;
         end else if (o_commit.valid) begin
            check_commit(o_commit, exp_q.pop_front(), "o_commit");
         end
         @(negedge i_clock);
      end
      if (exp_q.size() != 0) begin
         $display("Error at %0t: %s halted with %0d commits missing", $time, name, exp_q.size());
         error_count++;
      end
      // Nothing younger than HALT commits
      repeat (4) begin
         @(negedge i_clock);
         check_halt(o_halted, 1'b1, "o_halted");
         check_commit(o_commit, idle_commit, "o_commit");
      end
   endtask

   task automatic report_test(input string name, input int base);
      test_count++;
      if (error_count == base) begin
         $display("Test %s: ok", name);
      end else begin
         fail_tests++;
         $display("Test %s: %0d errors", name, error_count - base);
      end
   endtask

   task automatic test_alu_chain();
      int base;
      base = error_count;
      prog = {itype(ADDI_OP, 1, 0, 12), itype(ADDI_OP, 2, 0, -3), rtype(ADDU_FN, 3, 1, 2),
              rtype(SUBU_FN, 4, 3, 1), rtype(AND_FN, 5, 4, 3), rtype(OR_FN, 6, 5, 4),
              rtype(SLT_FN, 7, 2, 6), rtype(SLT_FN, 1, 6, 2), rtype(SUBU_FN, 2, 2, 7), HALT_WORD};
      run_program("alu chain");
      report_test("alu chain", base);
   endtask

   task automatic test_addi_r0();
      int base;
      base = error_count;
      prog = {itype(ADDI_OP, 1, 0, -5), itype(ADDI_OP, 2, 1, -100), itype(ADDI_OP, 0, 1, 3),
              rtype(ADDU_FN, 0, 1, 2), rtype(ADDU_FN, 5, 0, 1), itype(ADDI_OP, 3, 0, 32767),
              itype(ADDI_OP, 4, 3, -32768), HALT_WORD};
      run_program("addi and r0");
      report_test("addi and r0", base);
   endtask

   task automatic test_load_store();
      int base;
      base = error_count;
      prog = {itype(ADDI_OP, 1, 0, 'h40), itype(ADDI_OP, 2, 0, -2), itype(SW_OP, 2, 1, 0),
              itype(LW_OP, 3, 1, 0), rtype(ADDU_FN, 4, 3, 1), itype(SW_OP, 4, 1, 4),
              itype(LW_OP, 5, 1, 4), itype(SW_OP, 5, 1, 8), itype(LW_OP, 6, 1, 8),
              rtype(OR_FN, 7, 6, 6), HALT_WORD};
      run_program("load store");
      report_test("load store", base);
   endtask

   task automatic test_branches();
      int base;
      base = error_count;
      prog = {itype(ADDI_OP, 1, 0, 5), itype(ADDI_OP, 2, 0, 5), itype(BEQ_OP, 2, 1, 1),
              itype(ADDI_OP, 3, 0, 99), itype(ADDI_OP, 4, 0, 7), itype(BEQ_OP, 1, 4, 1),
              itype(ADDI_OP, 5, 0, 1), itype(SW_OP, 1, 0, 'h80), itype(LW_OP, 6, 0, 'h80),
              itype(BEQ_OP, 1, 6, 1), itype(ADDI_OP, 7, 0, 1), jump(13),
              itype(ADDI_OP, 3, 0, 55), rtype(ADDU_FN, 7, 6, 5), HALT_WORD};
      run_program("branches");
      report_test("branches", base);
   endtask

   task automatic test_halt();
      mips_pkg::commit_t idle_commit;
      int                base;
      idle_commit = '0;
      base        = error_count;
      prog = {itype(ADDI_OP, 1, 0, 1), itype(ADDI_OP, 2, 1, 1), HALT_WORD,
              itype(ADDI_OP, 3, 0, 3), itype(ADDI_OP, 4, 0, 4)};
      run_program("halt");
      reset_dut();
      @(negedge i_clock);
      check_halt(o_halted, 1'b0, "o_halted");
      check_commit(o_commit, idle_commit, "o_commit");
      report_test("halt", base);
   endtask

   task automatic test_random();
      int base;
      int len;
      int kind;
      base = error_count;
      for (int n = 0; n < 20; n++) begin
         prog.delete();
         len = $urandom_range(16, 8);
         for (int k = 0; k < len; k++) begin
            kind = $urandom_range(5, 0);
            if (kind == 5) begin
               prog.push_back(itype(ADDI_OP, $urandom_range(7, 1), $urandom_range(7, 1),
                                    $urandom_range(65535, 0)));
            end else begin
               prog.push_back(rtype(ALU_FNS[kind], $urandom_range(7, 1), $urandom_range(7, 1),
                                    $urandom_range(7, 1)));
            end
         end
         prog.push_back(HALT_WORD);
         run_program($sformatf("random program %0d", n));
      end
      report_test("random programs", base);
   endtask

   initial begin
      i_clock      = 1'b0;
      reset        = 1'b1;
      i_run        = 1'b0;
      i_imem_write = '0;
      void'($urandom(46));
      test_alu_chain();
      test_addi_r0();
      test_load_store();
      test_branches();
      test_halt();
      test_random();
      $display("Tests run: %0d, failed: %0d, errors: %0d", test_count, fail_tests, error_count);
      if (error_count == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
